// ==== cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    //----------------------------------------------------------------------
    // widths
    //----------------------------------------------------------------------
    localparam int XLEN       = 32;     // data and address, one word
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;      // x0..x31

    //----------------------------------------------------------------------
    // decoded fields
    //----------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,                // also the bubble value
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } aluOp_t;

    typedef enum logic [2:0] {
        LS_LB  = 3'd0,
        LS_LH  = 3'd1,
        LS_LW  = 3'd2,
        LS_LBU = 3'd3,
        LS_LHU = 3'd4,
        LS_SB  = 3'd5,
        LS_SH  = 3'd6,
        LS_SW  = 3'd7
    } lsType_t;

    typedef enum logic [2:0] {
        EXC_NONE     = 3'd0,
        EXC_ILLEGAL  = 3'd1,
        EXC_ECALL    = 3'd2,
        EXC_EBREAK   = 3'd3,
        EXC_MISALIGN = 3'd4             // raised by address generation
    } except_t;

    // what a stage register does at the next edge
    typedef enum logic [1:0] {
        ACT_HOLD   = 2'd0,
        ACT_LOAD   = 2'd1,
        ACT_BUBBLE = 2'd2
    } stageAction_t;

endpackage

`default_nettype wire

// ==== hazardCtrl.sv ====
`default_nettype none

module hazardCtrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 bruTaken,
    input  logic                 stall,
    input  logic                 kill,
    input  logic                 flush,
    input  logic                 lsuStallReq,
    output cpuPkg::stageAction_t ifDecAction,
    output cpuPkg::stageAction_t decExAction,
    output cpuPkg::stageAction_t exLsAction,
    output cpuPkg::stageAction_t lsWbAction
);

    logic                 lsuStallQ;    // lsu request from last cycle
    logic                 squash;
    logic                 frontBubble;
    cpuPkg::stageAction_t frontAction;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lsuStallQ <= 1'b0;
        end else begin
            lsuStallQ <= lsuStallReq;
        end
    end

    assign squash      = kill | flush;
    assign frontBubble = squash | (bruTaken & ~stall);   // taken branch kills wrong path

    always_comb begin
        if (frontBubble) begin
            frontAction = cpuPkg::ACT_BUBBLE;
        end else if (stall) begin
            frontAction = cpuPkg::ACT_HOLD;
        end else begin
            frontAction = cpuPkg::ACT_LOAD;
        end

        if (squash) begin
            exLsAction = cpuPkg::ACT_BUBBLE;
            lsWbAction = cpuPkg::ACT_BUBBLE;
        end else begin
            exLsAction = stall ? cpuPkg::ACT_HOLD : cpuPkg::ACT_LOAD;
            // writeback drains the load the lsu stalled for
            lsWbAction = (!stall || lsuStallQ) ? cpuPkg::ACT_LOAD : cpuPkg::ACT_HOLD;
        end
    end

    assign ifDecAction = frontAction;
    assign decExAction = frontAction;

    squashBubblesAll: assert property (@(posedge clk) disable iff (rst)
        squash |-> (ifDecAction == cpuPkg::ACT_BUBBLE && decExAction == cpuPkg::ACT_BUBBLE &&
                    exLsAction == cpuPkg::ACT_BUBBLE && lsWbAction == cpuPkg::ACT_BUBBLE));

    exLsBubbleOnlySquash: assert property (@(posedge clk) disable iff (rst)
        (exLsAction == cpuPkg::ACT_BUBBLE) |-> squash);

endmodule

`default_nettype wire

// ==== ifDecReg.sv ====
`default_nettype none

module ifDecReg (
    input  logic                      clk,
    input  logic                      rst,
    input  cpuPkg::stageAction_t      action,
    input  logic [cpuPkg::INST_W-1:0] inst,
    input  logic [cpuPkg::XLEN-1:0]   instAddr,
    output logic [cpuPkg::INST_W-1:0] idInst,
    output logic [cpuPkg::XLEN-1:0]   idInstAddr
);

    //----------------------------------------------------------------------
    // fetch/decode register
    //----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idInst     <= '0;
            idInstAddr <= '0;
        end else begin
            case (action)
                cpuPkg::ACT_LOAD: begin
                    idInst     <= inst;
                    idInstAddr <= instAddr;
                end
                cpuPkg::ACT_BUBBLE: begin
                    idInst     <= '0;       // nop slot
                    idInstAddr <= '0;
                end
                default: begin
                    idInst     <= idInst;   // hold
                    idInstAddr <= idInstAddr;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== decExReg.sv ====
`default_nettype none

module decExReg (
    input  logic                          clk,
    input  logic                          rst,
    input  cpuPkg::stageAction_t          action,
    input  logic [cpuPkg::INST_W-1:0]     idInst,
    input  logic [cpuPkg::XLEN-1:0]       idInstAddr,
    input  logic [cpuPkg::XLEN-1:0]       rs1Data,
    input  logic [cpuPkg::XLEN-1:0]       rs2Data,
    input  logic [cpuPkg::XLEN-1:0]       imm,
    input  logic                          rdWe,
    input  logic [cpuPkg::REG_ADDR_W-1:0] rdAddr,
    input  cpuPkg::aluOp_t                aluOp,
    input  logic                          lsValid,
    input  cpuPkg::lsType_t               lsType,
    input  cpuPkg::except_t               except,
    output logic [cpuPkg::INST_W-1:0]     exInst,
    output logic [cpuPkg::XLEN-1:0]       exInstAddr,
    output logic [cpuPkg::XLEN-1:0]       exRs1Data,
    output logic [cpuPkg::XLEN-1:0]       exRs2Data,
    output logic [cpuPkg::XLEN-1:0]       exImm,
    output logic                          exRdWe,
    output logic [cpuPkg::REG_ADDR_W-1:0] exRdAddr,
    output cpuPkg::aluOp_t                exAluOp,
    output logic                          exLsValid,
    output cpuPkg::lsType_t               exLsType,
    output cpuPkg::except_t               exExcept
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exInst     <= '0;
            exInstAddr <= '0;
            exRs1Data  <= '0;
            exRs2Data  <= '0;
            exImm      <= '0;
            exRdWe     <= 1'b0;
            exRdAddr   <= '0;
            exAluOp    <= cpuPkg::ALU_ADD;
            exLsValid  <= 1'b0;
            exLsType   <= cpuPkg::LS_LB;
            exExcept   <= cpuPkg::EXC_NONE;
        end else if (action == cpuPkg::ACT_BUBBLE) begin
            exInst     <= '0;
            exInstAddr <= '0;
            exRs1Data  <= '0;
            exRs2Data  <= '0;
            exImm      <= '0;
            exRdWe     <= 1'b0;             // no writeback from a bubble
            exRdAddr   <= '0;
            exAluOp    <= cpuPkg::ALU_ADD;
            exLsValid  <= 1'b0;
            exLsType   <= cpuPkg::LS_LB;
            exExcept   <= cpuPkg::EXC_NONE;
        end else if (action == cpuPkg::ACT_LOAD) begin
            exInst     <= idInst;
            exInstAddr <= idInstAddr;
            exRs1Data  <= rs1Data;
            exRs2Data  <= rs2Data;
            exImm      <= imm;
            exRdWe     <= rdWe;
            exRdAddr   <= rdAddr;
            exAluOp    <= aluOp;
            exLsValid  <= lsValid;
            exLsType   <= lsType;
            exExcept   <= except;
        end
    end

    bubbleIsInert: assert property (@(posedge clk) disable iff (rst)
        (action == cpuPkg::ACT_BUBBLE) |=> (!exRdWe && !exLsValid));

endmodule

`default_nettype wire

// ==== exLsReg.sv ====
`default_nettype none

module exLsReg (
    input  logic                          clk,
    input  logic                          rst,
    input  cpuPkg::stageAction_t          action,
    input  logic [cpuPkg::INST_W-1:0]     exInst,
    input  logic [cpuPkg::XLEN-1:0]       exInstAddr,
    input  logic                          exRdWe,
    input  logic [cpuPkg::REG_ADDR_W-1:0] exRdAddr,
    input  logic                          exLsValid,
    input  cpuPkg::lsType_t               exLsType,
    input  cpuPkg::except_t               exExcept,
    input  logic [cpuPkg::XLEN-1:0]       rdWdata,
    input  logic [cpuPkg::XLEN-1:0]       memAddr,
    input  logic [cpuPkg::XLEN-1:0]       storeData,
    output logic [cpuPkg::INST_W-1:0]     lsInst,
    output logic [cpuPkg::XLEN-1:0]       lsInstAddr,
    output logic                          lsRdWe,
    output logic [cpuPkg::REG_ADDR_W-1:0] lsRdAddr,
    output logic [cpuPkg::XLEN-1:0]       lsRdWdata,
    output logic [cpuPkg::XLEN-1:0]       lsMemAddr,
    output logic [cpuPkg::XLEN-1:0]       lsStoreData,
    output logic                          lsValid,
    output cpuPkg::lsType_t               lsType,
    output cpuPkg::except_t               lsExcept
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst || action == cpuPkg::ACT_BUBBLE) begin
            lsInst      <= '0;
            lsInstAddr  <= '0;
            lsRdWe      <= 1'b0;
            lsRdAddr    <= '0;
            lsRdWdata   <= '0;
            lsMemAddr   <= '0;
            lsStoreData <= '0;
            lsValid     <= 1'b0;            // no memory access
            lsType      <= cpuPkg::LS_LB;
            lsExcept    <= cpuPkg::EXC_NONE;
        end else if (action == cpuPkg::ACT_LOAD) begin
            lsInst      <= exInst;
            lsInstAddr  <= exInstAddr;
            lsRdWe      <= exRdWe;
            lsRdAddr    <= exRdAddr;
            lsRdWdata   <= rdWdata;         // alu result
            lsMemAddr   <= memAddr;
            lsStoreData <= storeData;
            lsValid     <= exLsValid;
            lsType      <= exLsType;
            lsExcept    <= exExcept;
        end
    end

    // a memory access only carries an address fault
    accessExcept: assert property (@(posedge clk) disable iff (rst)
        lsValid |-> (lsExcept inside {cpuPkg::EXC_NONE, cpuPkg::EXC_MISALIGN}));

endmodule

`default_nettype wire

// ==== lsWbReg.sv ====
`default_nettype none

module lsWbReg (
    input  logic                          clk,
    input  logic                          rst,
    input  cpuPkg::stageAction_t          action,
    input  logic [cpuPkg::INST_W-1:0]     lsInst,
    input  logic [cpuPkg::XLEN-1:0]       lsInstAddr,
    input  logic                          lsRdWe,
    input  logic [cpuPkg::REG_ADDR_W-1:0] lsRdAddr,
    input  logic [cpuPkg::XLEN-1:0]       rdWdata,
    output logic [cpuPkg::INST_W-1:0]     wbInst,
    output logic [cpuPkg::XLEN-1:0]       wbInstAddr,
    output logic                          wbRdWe,
    output logic [cpuPkg::REG_ADDR_W-1:0] wbRdAddr,
    output logic [cpuPkg::XLEN-1:0]       wbRdWdata
);

    //----------------------------------------------------------------------
    // load-store/writeback register
    //----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst || action == cpuPkg::ACT_BUBBLE) begin
            wbInst     <= '0;
            wbInstAddr <= '0;
            wbRdWe     <= 1'b0;
            wbRdAddr   <= '0;
            wbRdWdata  <= '0;
        end else if (action == cpuPkg::ACT_LOAD) begin
            wbInst     <= lsInst;
            wbInstAddr <= lsInstAddr;
            wbRdWe     <= lsRdWe;
            wbRdAddr   <= lsRdAddr;
            wbRdWdata  <= rdWdata;          // load data or passed result
        end
    end

    // register file sees no write right out of reset
    resetIsQuiet: assert property (@(posedge clk)
        rst |=> (!wbRdWe && wbRdAddr == '0 && wbRdWdata == '0 &&
                 wbInst == '0 && wbInstAddr == '0));

endmodule

`default_nettype wire

// ==== pipeRegs.sv ====
`default_nettype none

module pipeRegs (
    input  logic                          clk,
    input  logic                          rst,
    // fetch side
    input  logic [cpuPkg::INST_W-1:0]     fetchInst,
    input  logic [cpuPkg::XLEN-1:0]       fetchAddr,
    // decode side
    input  logic [cpuPkg::XLEN-1:0]       decRs1Data,
    input  logic [cpuPkg::XLEN-1:0]       decRs2Data,
    input  logic [cpuPkg::XLEN-1:0]       decImm,
    input  logic                          decRdWe,
    input  logic [cpuPkg::REG_ADDR_W-1:0] decRdAddr,
    input  cpuPkg::aluOp_t                decAluOp,
    input  logic                          decLsValid,
    input  cpuPkg::lsType_t               decLsType,
    input  cpuPkg::except_t               decExcept,
    // execute and load-store side
    input  logic [cpuPkg::XLEN-1:0]       exResult,
    input  logic [cpuPkg::XLEN-1:0]       exMemAddr,
    input  logic [cpuPkg::XLEN-1:0]       exStoreData,
    input  logic [cpuPkg::XLEN-1:0]       lsResult,
    // pipeline control
    input  logic                          bruTaken,
    input  logic                          stall,
    input  logic                          kill,
    input  logic                          flush,
    input  logic                          lsuStallReq,
    // stage outputs
    output logic [cpuPkg::INST_W-1:0]     idInst,
    output logic [cpuPkg::XLEN-1:0]       idInstAddr,
    output logic [cpuPkg::INST_W-1:0]     exInst,
    output logic [cpuPkg::XLEN-1:0]       exInstAddr,
    output logic [cpuPkg::XLEN-1:0]       exRs1Data,
    output logic [cpuPkg::XLEN-1:0]       exRs2Data,
    output logic [cpuPkg::XLEN-1:0]       exImm,
    output logic                          exRdWe,
    output logic [cpuPkg::REG_ADDR_W-1:0] exRdAddr,
    output cpuPkg::aluOp_t                exAluOp,
    output logic                          exLsValid,
    output cpuPkg::lsType_t               exLsType,
    output cpuPkg::except_t               exExcept,
    output logic [cpuPkg::INST_W-1:0]     lsInst,
    output logic [cpuPkg::XLEN-1:0]       lsInstAddr,
    output logic                          lsRdWe,
    output logic [cpuPkg::REG_ADDR_W-1:0] lsRdAddr,
    output logic [cpuPkg::XLEN-1:0]       lsRdWdata,
    output logic [cpuPkg::XLEN-1:0]       lsMemAddr,
    output logic [cpuPkg::XLEN-1:0]       lsStoreData,
    output logic                          lsValid,
    output cpuPkg::lsType_t               lsType,
    output cpuPkg::except_t               lsExcept,
    output logic [cpuPkg::INST_W-1:0]     wbInst,
    output logic [cpuPkg::XLEN-1:0]       wbInstAddr,
    output logic                          wbRdWe,
    output logic [cpuPkg::REG_ADDR_W-1:0] wbRdAddr,
    output logic [cpuPkg::XLEN-1:0]       wbRdWdata
);

    cpuPkg::stageAction_t ifDecAction;
    cpuPkg::stageAction_t decExAction;
    cpuPkg::stageAction_t exLsAction;
    cpuPkg::stageAction_t lsWbAction;

    hazardCtrl hazard (
        .clk, .rst, .bruTaken, .stall, .kill, .flush, .lsuStallReq,
        .ifDecAction, .decExAction, .exLsAction, .lsWbAction
    );

    //----------------------------------------------------------------------
    // stage register chain
    //----------------------------------------------------------------------
    ifDecReg ifDec (
        .clk, .rst, .action(ifDecAction),
        .inst(fetchInst), .instAddr(fetchAddr),
        .idInst, .idInstAddr
    );

    decExReg decEx (
        .clk, .rst, .action(decExAction),
        .idInst, .idInstAddr,
        .rs1Data(decRs1Data), .rs2Data(decRs2Data), .imm(decImm),
        .rdWe(decRdWe), .rdAddr(decRdAddr), .aluOp(decAluOp),
        .lsValid(decLsValid), .lsType(decLsType), .except(decExcept),
        .exInst, .exInstAddr, .exRs1Data, .exRs2Data, .exImm,
        .exRdWe, .exRdAddr, .exAluOp, .exLsValid, .exLsType, .exExcept
    );

    exLsReg exLs (
        .clk, .rst, .action(exLsAction),
        .exInst, .exInstAddr, .exRdWe, .exRdAddr,
        .exLsValid, .exLsType, .exExcept,
        .rdWdata(exResult), .memAddr(exMemAddr), .storeData(exStoreData),
        .lsInst, .lsInstAddr, .lsRdWe, .lsRdAddr, .lsRdWdata,
        .lsMemAddr, .lsStoreData, .lsValid, .lsType, .lsExcept
    );

    lsWbReg lsWb (
        .clk, .rst, .action(lsWbAction),
        .lsInst, .lsInstAddr, .lsRdWe, .lsRdAddr,
        .rdWdata(lsResult),                 // load data from the lsu
        .wbInst, .wbInstAddr, .wbRdWe, .wbRdAddr, .wbRdWdata
    );

endmodule

`default_nettype wire

// ==== pipeRegsChecks.sv ====
`default_nettype none

module pipeRegsChecks (
    input  logic         clk,
    input  logic         rst,
    input  logic         bruTaken,
    input  logic         stall,
    input  logic         kill,
    input  logic         flush,
    input  logic         lsuStallReq,
    input  logic [63:0]  fetchVec,      // inst, addr
    input  logic [112:0] decVec,        // decode side fields in port order
    input  logic [95:0]  exVec,         // result, mem addr, store data
    input  logic [31:0]  lsResult,
    input  logic [63:0]  idStage,
    input  logic [176:0] exStage,
    input  logic [172:0] lsStage,
    input  logic [101:0] wbStage,
    output int           errors
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [63:0]  sId;
    logic [176:0] sEx;
    logic [172:0] sLs;
    logic [101:0] sWb;
    logic         lsuReqQ;
    logic         squash;
    logic         frontSquash;
    int           errCount = 0;

    assign errors      = errCount;
    assign squash      = kill | flush;
    assign frontSquash = squash | (bruTaken & ~stall);

    //----------------------------------------------------------------------
    // shadow model of the four stage registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sId     <= '0;
            sEx     <= '0;
            sLs     <= '0;
            sWb     <= '0;
            lsuReqQ <= 1'b0;
        end else begin
            lsuReqQ <= lsuStallReq;
            if (frontSquash) begin
                sId <= '0;
                sEx <= '0;
            end else if (!stall) begin
                sId <= fetchVec;
                sEx <= {sId, decVec};
            end
            if (squash) begin
                sLs <= '0;
                sWb <= '0;
            end else begin
                if (!stall) begin
                    sLs <= {sEx[176:113], sEx[16:11], exVec, sEx[6:0]};
                end
                if (!stall || lsuReqQ) begin
                    sWb <= {sLs[172:103], lsResult};   // inst, addr, rdWe, rdAddr
                end
            end
        end
    end

    //----------------------------------------------------------------------
    // output checks
    //----------------------------------------------------------------------
    resetZero: assert property (@(posedge clk)
        rst |-> ({idStage, exStage, lsStage, wbStage} == '0))
        else begin
            $display("Error at %0t: stage outputs are not zero during reset", $time);
            errCount++;
        end

    idMatch: assert property (@(posedge clk) idStage == sId)
        else begin
            $display("Error at %0t: idStage is %h, expected %h", $time, idStage, sId);
            errCount++;
        end

    exMatch: assert property (@(posedge clk) exStage == sEx)
        else begin
            $display("Error at %0t: exStage is %h, expected %h", $time, exStage, sEx);
            errCount++;
        end

    lsMatch: assert property (@(posedge clk) lsStage == sLs)
        else begin
            $display("Error at %0t: lsStage is %h, expected %h", $time, lsStage, sLs);
            errCount++;
        end

    wbMatch: assert property (@(posedge clk) wbStage == sWb)
        else begin
            $display("Error at %0t: wbStage is %h, expected %h", $time, wbStage, sWb);
            errCount++;
        end

endmodule

`default_nettype wire

// ==== pipeRegsTb.sv ====
`default_nettype none

module pipeRegsTb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                          clk;
    logic                          rst;
    logic [cpuPkg::INST_W-1:0]     fetchInst;
    logic [cpuPkg::XLEN-1:0]       fetchAddr, decRs1Data, decRs2Data, decImm;
    logic                          decRdWe, decLsValid;
    logic [cpuPkg::REG_ADDR_W-1:0] decRdAddr;
    cpuPkg::aluOp_t                decAluOp;
    cpuPkg::lsType_t               decLsType;
    cpuPkg::except_t               decExcept;
    logic [cpuPkg::XLEN-1:0]       exResult, exMemAddr, exStoreData, lsResult;
    logic                          bruTaken, stall, kill, flush, lsuStallReq;

    logic [cpuPkg::INST_W-1:0]     idInst, exInst, lsInst, wbInst;
    logic [cpuPkg::XLEN-1:0]       idInstAddr, exInstAddr, exRs1Data, exRs2Data, exImm;
    logic [cpuPkg::XLEN-1:0]       lsInstAddr, lsRdWdata, lsMemAddr, lsStoreData;
    logic [cpuPkg::XLEN-1:0]       wbInstAddr, wbRdWdata;
    logic                          exRdWe, exLsValid, lsRdWe, lsValid, wbRdWe;
    logic [cpuPkg::REG_ADDR_W-1:0] exRdAddr, lsRdAddr, wbRdAddr;
    cpuPkg::aluOp_t                exAluOp;
    cpuPkg::lsType_t               exLsType, lsType;
    cpuPkg::except_t               exExcept, lsExcept;

    logic [31:0] lfsr = 32'h5767;
    logic [31:0] lastInst;                  // last word presented at fetch
    logic [31:0] heldInst;
    int          checkErrors;
    int          errorsAtStart = 0;
    int          testCount = 0;
    int          failedTests = 0;

    pipeRegs uut (.*);

    pipeRegsChecks checks (
        .clk, .rst, .bruTaken, .stall, .kill, .flush, .lsuStallReq, .lsResult,
        .fetchVec({fetchInst, fetchAddr}),
        .decVec({decRs1Data, decRs2Data, decImm, decRdWe, decRdAddr, decAluOp,
                 decLsValid, decLsType, decExcept}),
        .exVec({exResult, exMemAddr, exStoreData}),
        .idStage({idInst, idInstAddr}),
        .exStage({exInst, exInstAddr, exRs1Data, exRs2Data, exImm, exRdWe, exRdAddr,
                  exAluOp, exLsValid, exLsType, exExcept}),
        .lsStage({lsInst, lsInstAddr, lsRdWe, lsRdAddr, lsRdWdata, lsMemAddr,
                  lsStoreData, lsValid, lsType, lsExcept}),
        .wbStage({wbInst, wbInstAddr, wbRdWe, wbRdAddr, wbRdWdata}),
        .errors(checkErrors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic driveStageInputs();
        logic [31:0] r;
        lastInst = randBits(32);
        r = randBits(16);
        fetchInst   <= lastInst;
        fetchAddr   <= randBits(32) & 32'hffff_fffc;
        decRs1Data  <= randBits(32);
        decRs2Data  <= randBits(32);
        decImm      <= randBits(32);
        exResult    <= randBits(32);
        exMemAddr   <= randBits(32);
        exStoreData <= randBits(32);
        lsResult    <= randBits(32);
        decRdWe     <= r[0];
        decRdAddr   <= r[5:1];
        decAluOp    <= (r[9:6] > 4'd9) ? cpuPkg::ALU_ADD : cpuPkg::aluOp_t'(r[9:6]);
        decLsValid  <= r[10];
        decLsType   <= cpuPkg::lsType_t'(r[13:11]);
        // memory ops only fault on alignment
        if (r[10]) begin
            decExcept <= r[14] ? cpuPkg::EXC_MISALIGN : cpuPkg::EXC_NONE;
        end else begin
            decExcept <= cpuPkg::except_t'({1'b0, r[15:14]});
        end
    endtask

    task automatic runCycle(input logic b, input logic s, input logic k, input logic f,
                            input logic l);
        @(posedge clk);
        driveStageInputs();
        bruTaken    <= b;
        stall       <= s;
        kill        <= k;
        flush       <= f;
        lsuStallReq <= l;
    endtask

    task automatic waitForWb(input logic [31:0] inst, input int limit);
        int  n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (wbInst === inst) begin
                done = 1'b1;
            end else if (n == limit) begin
                $display("timeout: instruction %h never reached writeback", inst);
                $display("SIMULATION FAILED");
                $finish;
            end else begin
                n++;
                runCycle(0, 0, 0, 0, 0);
            end
        end
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (checkErrors == errorsAtStart) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: %0d errors", testCount, name, checkErrors - errorsAtStart);
        end
        errorsAtStart = checkErrors;
    endtask

    //----------------------------------------------------------------------
    // test sequence
    //----------------------------------------------------------------------
    initial begin
        rst = 1'b1;
        {fetchInst, fetchAddr, decRs1Data, decRs2Data, decImm} = '0;
        {exResult, exMemAddr, exStoreData, lsResult} = '0;
        {decRdWe, decRdAddr, decLsValid} = '0;
        decAluOp  = cpuPkg::ALU_ADD;
        decLsType = cpuPkg::LS_LB;
        decExcept = cpuPkg::EXC_NONE;
        {bruTaken, stall, kill, flush, lsuStallReq} = '0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        endTest("reset");

        repeat (8) runCycle(0, 0, 0, 0, 0);
        waitForWb(lastInst, 8);
        endTest("flow");

        @(negedge clk);
        heldInst = idInst;
        repeat (5) runCycle(0, 1, 0, 0, 0);
        runCycle(0, 0, 0, 0, 0);
        waitForWb(heldInst, 8);
        endTest("stall");

        runCycle(1, 0, 0, 0, 0);            // branch bubbles the front
        repeat (3) runCycle(0, 0, 0, 0, 0);
        repeat (2) runCycle(1, 1, 0, 0, 0); // stalled branch holds
        repeat (3) runCycle(0, 0, 0, 0, 0);
        endTest("branch");

        runCycle(0, 0, 1, 0, 0);
        repeat (3) runCycle(0, 0, 0, 0, 0);
        runCycle(0, 1, 0, 1, 0);
        repeat (3) runCycle(0, 0, 0, 0, 0);
        endTest("kill and flush");

        runCycle(0, 0, 0, 0, 1);
        repeat (2) runCycle(0, 1, 0, 0, 0); // writeback drains once, then holds
        repeat (4) runCycle(0, 0, 0, 0, 0);
        waitForWb(lastInst, 8);
        endTest("lsu stall");

        @(posedge clk);
        @(negedge clk);
        $display("tests %0d, tests with errors %0d, check errors %0d",
                 testCount, failedTests, checkErrors);
        if (checkErrors == 0 && failedTests == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
cpuPkg.sv
hazardCtrl.sv
ifDecReg.sv
decExReg.sv
exLsReg.sv
lsWbReg.sv
pipeRegs.sv
pipeRegsChecks.sv
pipeRegsTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# build and run the pipeline register testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module pipeRegsTb -o pipeRegsSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/pipeRegsSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
